// File: Makefile
TOOL     = verilator
TOP      = decodeStage_tb
FILELIST = src.f
FLAGS    = --binary --assert -j 0 -Mdir obj_dir --top-module $(TOP)
BIN      = obj_dir/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) mips_defines.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: aluDecoder.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module aluDecoder (
	input  decodePkg::aluOpT aluOp,
	input  logic [5:0] funct,
	output decodePkg::aluCtrlT aluCtrl
);

	always_comb begin
		case (aluOp)
			`R_TYPE_OP: begin
				case (funct)
					`ADD: aluCtrl = `ALU_ADD;
					`ADDU: aluCtrl = `ALU_ADDU;
					`SUB: aluCtrl = `ALU_SUB;
					`SUBU: aluCtrl = `ALU_SUBU;
					`AND: aluCtrl = `ALU_AND;
					`OR: aluCtrl = `ALU_OR;
					`XOR: aluCtrl = `ALU_XOR;
					`NOR: aluCtrl = `ALU_NOR;
					`SLT: aluCtrl = `ALU_SLT;
					`SLTU: aluCtrl = `ALU_SLTU;
					`SLL: aluCtrl = `ALU_SLL;
					`SRL: aluCtrl = `ALU_SRL;
					`SRA: aluCtrl = `ALU_SRA;
					`SLLV: aluCtrl = `ALU_SLLV;
					`SRLV: aluCtrl = `ALU_SRLV;
					`SRAV: aluCtrl = `ALU_SRAV;
					`MOVZ: aluCtrl = `ALU_MOVZ;
					`MOVN: aluCtrl = `ALU_MOVN;
					default: aluCtrl = `ALU_PASS;   // jumps, hi/lo moves, traps
				endcase
			end
			`SPECIAL2_OP: begin
				case (funct)
					`CLO: aluCtrl = `ALU_CLO;
					`CLZ: aluCtrl = `ALU_CLZ;
					`MUL: aluCtrl = `ALU_MUL;
					default: aluCtrl = `ALU_PASS;   // madd/msub go to the mul unit
				endcase
			end
			`ADDI_OP: aluCtrl = `ALU_ADD;
			`ADDIU_OP, `MEM_OP: aluCtrl = `ALU_ADDU;   // address calc never traps
			`SLTI_OP: aluCtrl = `ALU_SLT;
			`SLTIU_OP: aluCtrl = `ALU_SLTU;
			`ANDI_OP: aluCtrl = `ALU_AND;
			`ORI_OP: aluCtrl = `ALU_OR;
			`XORI_OP: aluCtrl = `ALU_XOR;
			`LUI_OP: aluCtrl = `ALU_LUI;
			`ROTR_OP: aluCtrl = `ALU_ROTR;
			`ROTRV_OP: aluCtrl = `ALU_ROTRV;
			`SEB_OP: aluCtrl = `ALU_SEB;
			`SEH_OP: aluCtrl = `ALU_SEH;
			`WSBH_OP: aluCtrl = `ALU_WSBH;
			`EXT_OP: aluCtrl = `ALU_EXT;
			`INS_OP: aluCtrl = `ALU_INS;
			default: aluCtrl = `ALU_PASS;   // cp0 moves and USELESS_OP
		endcase
	end

endmodule

// File: branchJudge.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module branchJudge (
	input  decodePkg::branchCtrlT branchCtrl,
	input  decodePkg::wordT rsValue,
	input  decodePkg::wordT rtValue,
	output logic taken
);
	logic equal;
	logic rsNeg;
	logic rsZero;

	assign equal = (rsValue == rtValue);
	assign rsNeg = rsValue[31];   // sign bit
	assign rsZero = (rsValue == '0);

	always_comb begin
		case (branchCtrl)
			`BR_EQ: taken = equal;
			`BR_NE: taken = !equal;
			`BR_LEZ: taken = rsNeg || rsZero;
			`BR_GTZ: taken = !rsNeg && !rsZero;
			`BR_LTZ: taken = rsNeg;
			`BR_GEZ: taken = !rsNeg;
			default: taken = 1'b0;   // not a branch
		endcase
	end

endmodule

// File: decodePkg.sv
package decodePkg;

	// instruction and data words
	typedef logic [31:0] instrT;
	typedef logic [31:0] wordT;

	typedef logic [4:0] regAddrT;

	// op class out of the main decoder
	typedef logic [5:0] aluOpT;

	// resolved ALU function
	typedef logic [4:0] aluCtrlT;

	// none, eq, ne, lez, gtz, ltz, gez
	typedef logic [2:0] branchCtrlT;

	// rd, rt or link register
	typedef logic [1:0] regDstT;

endpackage

// File: decodeStage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	output logic instrReady,
	input  decodePkg::instrT instr,
	input  logic wbEn,
	input  decodePkg::regAddrT wbAddr,
	input  decodePkg::wordT wbData,
	output logic exValid,
	input  logic exReady,
	output decodePkg::wordT exRsValue,
	output decodePkg::wordT exRtValue,
	output decodePkg::wordT exImm,
	output decodePkg::regAddrT exDestReg,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exMemToReg,
	output decodePkg::aluCtrlT exAluCtrl,
	output logic exBranchTaken,
	output logic exReserved,
	output logic exIsSyscall,
	output logic exIsBreak,
	output logic exIsEret,
	output logic exCp0Write,
	output logic exCp0ToReg,
	output logic exMulDivEn,
	output logic exHiloToReg
);
	logic signExt, regWrite, memRead, memWrite, memToReg, reserved;
	logic isBreak, isSyscall, isEret, cp0Write, cp0ToReg, hiloToReg, mulDivEn;
	decodePkg::regDstT regDst;
	decodePkg::aluOpT aluOp;
	decodePkg::branchCtrlT branchCtrl;
	decodePkg::aluCtrlT aluCtrl;
	decodePkg::wordT rsValue;
	decodePkg::wordT rtValue;
	decodePkg::wordT immExt;
	decodePkg::regAddrT destReg;
	logic taken;

	mainDecoder u_mainDecoder (
		.instr(instr), .signExt(signExt), .regWrite(regWrite), .isImm(),
		.memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
		.reserved(reserved), .isBreak(isBreak), .isSyscall(isSyscall), .isEret(isEret),
		.cp0Write(cp0Write), .cp0ToReg(cp0ToReg), .isMfc(), .mfhi(), .mflo(),
		.hiloToReg(hiloToReg), .mulDivEn(mulDivEn), .regDst(regDst),
		.aluOp(aluOp), .branchCtrl(branchCtrl)
	);

	aluDecoder u_aluDecoder (.aluOp(aluOp), .funct(instr[5:0]), .aluCtrl(aluCtrl));

	regFile u_regFile (
		.clk(clk), .rstN(rstN),
		.readAddrA(instr[25:21]), .readAddrB(instr[20:16]),
		.readDataA(rsValue), .readDataB(rtValue),
		.writeEn(wbEn), .writeAddr(wbAddr), .writeData(wbData)
	);

	branchJudge u_branchJudge (
		.branchCtrl(branchCtrl), .rsValue(rsValue), .rtValue(rtValue), .taken(taken)
	);

	always_comb begin
		case (regDst)
			`DST_RT: destReg = instr[20:16];
			`DST_LINK: destReg = `REG_LINK;
			default: destReg = instr[15:11];
		endcase
	end

	assign immExt = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

	// empty, or the held entry leaves this cycle
	assign instrReady = !exValid || exReady;

	always_ff @(posedge clk) begin
		if (!rstN)
			exValid <= 1'b0;
		else if (instrReady)
			exValid <= instrValid;
	end

	always_ff @(posedge clk) begin
		if (instrValid && instrReady) begin
			exRsValue <= rsValue;
			exRtValue <= rtValue;
			exImm <= immExt;
			exDestReg <= destReg;
			exRegWrite <= regWrite;
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			exMemToReg <= memToReg;
			exAluCtrl <= aluCtrl;
			exBranchTaken <= taken;
			exReserved <= reserved;
			exIsSyscall <= isSyscall;
			exIsBreak <= isBreak;
			exIsEret <= isEret;
			exCp0Write <= cp0Write;
			exCp0ToReg <= cp0ToReg;
			exMulDivEn <= mulDivEn;
			exHiloToReg <= hiloToReg;
		end
	end

	// stalled entry stays put
	assert property (@(posedge clk) disable iff (!rstN)
		(exValid && !exReady) |=> exValid && $stable({exRsValue, exRtValue, exImm,
			exDestReg, exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluCtrl,
			exBranchTaken, exReserved, exIsSyscall, exIsBreak, exIsEret,
			exCp0Write, exCp0ToReg, exMulDivEn, exHiloToReg}))
		else $error("decodeStage: ID/EX entry changed under back-pressure at %0t", $time);

endmodule

// File: decodeStage_tb.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module decodeStage_tb;
	localparam int randomCount = 150;
	localparam int directedCount = 120;
	localparam int watchdogNs = (directedCount + randomCount + 31) * 40 * 40 + 4000;

	// expected flags, in the order of the compared output vector
	localparam logic [11:0] fNone = 12'h000;
	localparam logic [11:0] fRegWrite = 12'h800;
	localparam logic [11:0] fMemRead = 12'h400;
	localparam logic [11:0] fMemWrite = 12'h200;
	localparam logic [11:0] fMemToReg = 12'h100;
	localparam logic [11:0] fReserved = 12'h080;
	localparam logic [11:0] fSyscall = 12'h040;
	localparam logic [11:0] fBreak = 12'h020;
	localparam logic [11:0] fEret = 12'h010;
	localparam logic [11:0] fCp0Write = 12'h008;
	localparam logic [11:0] fCp0ToReg = 12'h004;
	localparam logic [11:0] fMulDiv = 12'h002;
	localparam logic [11:0] fHiloToReg = 12'h001;

	typedef struct packed {
		decodePkg::wordT rsVal;
		decodePkg::wordT rtVal;
		decodePkg::wordT imm;
		decodePkg::regAddrT dest;
		decodePkg::aluCtrlT alu;
		logic taken;
		logic [11:0] flags;
	} expT;

	logic clk;
	logic rstN;
	logic instrValid;
	logic instrReady;
	decodePkg::instrT instr;
	logic wbEn;
	decodePkg::regAddrT wbAddr;
	decodePkg::wordT wbData;
	logic exValid;
	logic exReady = 1'b1;
	decodePkg::wordT exRsValue;
	decodePkg::wordT exRtValue;
	decodePkg::wordT exImm;
	decodePkg::regAddrT exDestReg;
	logic exRegWrite, exMemRead, exMemWrite, exMemToReg;
	decodePkg::aluCtrlT exAluCtrl;
	logic exBranchTaken, exReserved, exIsSyscall, exIsBreak, exIsEret;
	logic exCp0Write, exCp0ToReg, exMulDivEn, exHiloToReg;

	decodePkg::wordT mirror [32];   // register file as seen by the write-back stimulus
	expT expQ [$];
	decodePkg::instrT instrQ [$];
	expT pendExp;
	decodePkg::branchCtrlT pendCond;
	logic accepted = 1'b0;
	logic stallOn = 1'b0;
	int errCount = 0;
	int errMark = 0;
	int testCount = 0;
	int sentCount = 0;
	int checkCount = 0;

	logic [5:0] rFunct [14] = '{`ADD, `ADDU, `SUB, `SUBU, `AND, `OR, `XOR, `NOR,
		`SLT, `SLTU, `SLL, `SRA, `SLLV, `SRAV};
	decodePkg::aluCtrlT rAlu [14] = '{`ALU_ADD, `ALU_ADDU, `ALU_SUB, `ALU_SUBU, `ALU_AND,
		`ALU_OR, `ALU_XOR, `ALU_NOR, `ALU_SLT, `ALU_SLTU, `ALU_SLL, `ALU_SRA, `ALU_SLLV,
		`ALU_SRAV};

	tbClock u_tbClock (.clk(clk));

	decodeStage u_decodeStage (.*);

	function automatic decodePkg::instrT rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] funct);
		return {`R_TYPE, rs, rt, rd, sa, funct};
	endfunction

	function automatic decodePkg::instrT iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic judge(input decodePkg::branchCtrlT cond,
		input decodePkg::wordT a, input decodePkg::wordT b);
		case (cond)
			`BR_EQ: return a == b;
			`BR_NE: return a != b;
			`BR_LEZ: return $signed(a) <= 0;
			`BR_GTZ: return $signed(a) > 0;
			`BR_LTZ: return $signed(a) < 0;
			`BR_GEZ: return $signed(a) >= 0;
			default: return 1'b0;
		endcase
	endfunction

	// register 0 reads zero and a write-back in the same cycle wins
	function automatic decodePkg::wordT regRead(input decodePkg::regAddrT a);
		if (a == '0)
			return '0;
		if (wbEn && (wbAddr == a))
			return wbData;
		return mirror[a];
	endfunction

	// input handshake and register mirror
	always @(posedge clk) begin : sampleInputs
		expT e;
		// ready unless a stalled entry is held
		if (rstN)
			assert (instrReady === !(exValid && !exReady))
				else begin
					$display("mismatch at %0t: instrReady %b with exValid %b exReady %b",
						$time, instrReady, exValid, exReady);
					errCount++;
				end
		accepted = rstN && instrValid && instrReady;
		if (accepted) begin
			e = pendExp;
			e.rsVal = regRead(instr[25:21]);
			e.rtVal = regRead(instr[20:16]);
			e.taken = judge(pendCond, e.rsVal, e.rtVal);
			expQ.push_back(e);
			instrQ.push_back(instr);
		end
		if (wbEn && (wbAddr != '0))
			mirror[wbAddr] = wbData;
	end

	// held entry compared every cycle, popped on the output handshake
	always @(negedge clk) begin : checkOutputs
		expT got;
		expT want;
		exReady = stallOn ? (($urandom % 3) != 0) : 1'b1;   // seen by the next rising edge
		if (rstN && exValid) begin
			if (expQ.size() == 0) begin
				$display("output valid at %0t with no instruction pending", $time);
				errCount++;
			end else begin
				got = {exRsValue, exRtValue, exImm, exDestReg, exAluCtrl, exBranchTaken,
					exRegWrite, exMemRead, exMemWrite, exMemToReg, exReserved, exIsSyscall,
					exIsBreak, exIsEret, exCp0Write, exCp0ToReg, exMulDivEn, exHiloToReg};
				want = expQ[0];
				if (!want.flags[11])
					got.dest = want.dest;   // no write, dest unused
				assert (got === want)
					else begin
						$display("mismatch at %0t: instr %h got %h expected %h",
							$time, instrQ[0], got, want);
						errCount++;
					end
				if (exReady) begin
					void'(expQ.pop_front());
					void'(instrQ.pop_front());
					checkCount++;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) (exValid && !exReady) |=> exValid)
		else begin
			$display("stalled entry dropped at %0t", $time);
			errCount++;
		end

	task automatic send(input decodePkg::instrT i, input logic [11:0] fl,
		input decodePkg::regAddrT dest, input decodePkg::aluCtrlT alu,
		input decodePkg::branchCtrlT cond);
		logic zeroExt;
		zeroExt = i[31:26] inside {`ANDI, `ORI, `XORI, `LUI};
		pendExp = '0;
		pendExp.flags = fl;
		pendExp.dest = dest;
		pendExp.alu = alu;
		pendExp.imm = zeroExt ? {16'b0, i[15:0]} : {{16{i[15]}}, i[15:0]};
		pendCond = cond;
		instr = i;
		instrValid = 1'b1;
		do
			@(negedge clk);
		while (!accepted);
		instrValid = 1'b0;
		wbEn = 1'b0;
		sentCount++;
	endtask

	task automatic reportTest(input string name);
		do
			@(posedge clk);
		while (expQ.size() != 0);
		@(negedge clk);
		testCount++;
		$display("%s: %0d error(s)", name, errCount - errMark);
		errMark = errCount;
	endtask

	task automatic setStall(input logic on);
		@(posedge clk);
		stallOn = on;
		@(negedge clk);
	endtask

	task automatic loadRegs();
		int r;
		for (r = 1; r < 32; r++) begin
			wbEn = 1'b1;
			wbAddr = 5'(r);
			wbData = $urandom;
			@(negedge clk);
		end
		wbEn = 1'b0;
	endtask

	task automatic rTypeTest();
		decodePkg::regAddrT rs;
		decodePkg::regAddrT rt;
		decodePkg::regAddrT rd;
		int k;
		for (k = 0; k < 14; k++) begin
			rs = 5'($urandom);
			rt = 5'($urandom);
			rd = 5'($urandom);
			send(rType(rs, rt, rd, 5'd3, rFunct[k]), fRegWrite, rd, rAlu[k], `BR_NONE);
		end
		// spare bit picks rotate over logical shift
		send(rType({rs[4:1], 1'b0}, rt, rd, 5'd5, `SRL), fRegWrite, rd, `ALU_SRL, `BR_NONE);
		send(rType({rs[4:1], 1'b1}, rt, rd, 5'd5, `SRL), fRegWrite, rd, `ALU_ROTR, `BR_NONE);
		send(rType(rs, rt, rd, 5'd4, `SRLV), fRegWrite, rd, `ALU_SRLV, `BR_NONE);
		send(rType(rs, rt, rd, 5'd1, `SRLV), fRegWrite, rd, `ALU_ROTRV, `BR_NONE);
		send(rType(rs, rt, 5'd0, 5'd0, `MULT), fMulDiv, 5'd0, `ALU_PASS, `BR_NONE);
		send(rType(5'd0, 5'd0, rd, 5'd0, `MFHI), fRegWrite | fHiloToReg, rd, `ALU_PASS,
			`BR_NONE);
	endtask

	task automatic memImmTest();
		decodePkg::regAddrT rs;
		decodePkg::regAddrT rt;
		rs = 5'($urandom);
		rt = 5'($urandom);
		send(iType(`LW, rs, rt, 16'h8004), fRegWrite | fMemRead | fMemToReg, rt, `ALU_ADDU,
			`BR_NONE);
		send(iType(`LB, rt, rs, 16'h0007), fRegWrite | fMemRead | fMemToReg, rs, `ALU_ADDU,
			`BR_NONE);
		send(iType(`SW, rs, rt, 16'hfffc), fMemWrite, 5'd0, `ALU_ADDU, `BR_NONE);
		send(iType(`SB, rt, rs, 16'h0011), fMemWrite, 5'd0, `ALU_ADDU, `BR_NONE);
		send(iType(`ADDI, rs, rt, 16'h9000), fRegWrite, rt, `ALU_ADD, `BR_NONE);
		send(iType(`ANDI, rs, rt, 16'hf0f0), fRegWrite, rt, `ALU_AND, `BR_NONE);
		send(iType(`ORI, rs, rt, 16'h8001), fRegWrite, rt, `ALU_OR, `BR_NONE);
		send(iType(`XORI, rs, rt, 16'hffff), fRegWrite, rt, `ALU_XOR, `BR_NONE);
		send(iType(`LUI, 5'd0, rt, 16'h8765), fRegWrite, rt, `ALU_LUI, `BR_NONE);
	endtask

	task automatic branchTest();
		decodePkg::regAddrT rs;
		decodePkg::regAddrT rt;
		int k;
		for (k = 0; k < 8; k++) begin
			rs = 5'($urandom % 6);   // small range so $0 and equal pairs show up
			rt = (k % 2 == 0) ? rs : 5'($urandom % 6);
			send(iType(`BEQ, rs, rt, 16'h0010), fNone, 5'd0, `ALU_PASS, `BR_EQ);
			send(iType(`BNE, rs, rt, 16'h0010), fNone, 5'd0, `ALU_PASS, `BR_NE);
			send(iType(`BLEZ, rs, 5'd0, 16'hfff0), fNone, 5'd0, `ALU_PASS, `BR_LEZ);
			send(iType(`BGTZ, rs, 5'd0, 16'hfff0), fNone, 5'd0, `ALU_PASS, `BR_GTZ);
			send(iType(`REGIMM_INST, rs, `BLTZ, 16'h0020), fNone, 5'd0, `ALU_PASS, `BR_LTZ);
			send(iType(`REGIMM_INST, rs, `BGEZ, 16'h0020), fNone, 5'd0, `ALU_PASS, `BR_GEZ);
		end
		send({`JAL, 26'h0123456}, fRegWrite, `REG_LINK, `ALU_PASS, `BR_NONE);
		send(iType(`REGIMM_INST, rs, `BGEZAL, 16'h0040), fRegWrite, `REG_LINK, `ALU_PASS,
			`BR_GEZ);
		send(rType(rs, 5'd0, 5'd17, 5'd0, `JALR), fRegWrite, 5'd17, `ALU_PASS, `BR_NONE);
	endtask

	task automatic specialTest();
		send({6'b010011, 26'h0}, fReserved, 5'd0, `ALU_PASS, `BR_NONE);
		send({6'b111011, 26'h3ffffff}, fReserved, 5'd0, `ALU_PASS, `BR_NONE);
		send(rType(5'd1, 5'd2, 5'd3, 5'd0, 6'b000001), fReserved, 5'd0, `ALU_PASS, `BR_NONE);
		send(iType(`REGIMM_INST, 5'd4, 5'b00010, 16'h0), fReserved, 5'd0, `ALU_PASS, `BR_NONE);
		send({`SPECIAL2_INST, 5'd1, 5'd2, 5'd3, 5'd0, 6'b111111}, fReserved, 5'd0,
			`ALU_PASS, `BR_NONE);
		send({`SPECIAL3_INST, 5'd1, 5'd2, 5'd3, 5'b00000, `BSHFL}, fReserved, 5'd0,
			`ALU_PASS, `BR_NONE);
		send({`COP0_INST, 5'b00001, 21'h0}, fReserved, 5'd0, `ALU_PASS, `BR_NONE);
		send(rType(5'd0, 5'd0, 5'd0, 5'd0, `SYSCALL), fSyscall, 5'd0, `ALU_PASS, `BR_NONE);
		send(rType(5'd0, 5'd0, 5'd0, 5'd0, `BREAK), fBreak, 5'd0, `ALU_PASS, `BR_NONE);
		send({`COP0_INST, `ERET_RS, 15'h0, `ERET_FUNCT}, fEret, 5'd0, `ALU_PASS, `BR_NONE);
		send({`COP0_INST, `MTC0, 5'd7, 5'd12, 11'h0}, fCp0Write, 5'd0, `ALU_PASS, `BR_NONE);
		send({`COP0_INST, `MFC0, 5'd7, 5'd12, 11'h0}, fRegWrite | fCp0ToReg, 5'd7,
			`ALU_PASS, `BR_NONE);
	endtask

	task automatic randomTest();
		decodePkg::regAddrT rs;
		decodePkg::regAddrT rt;
		decodePkg::regAddrT rd;
		logic [15:0] imm;
		int k;
		for (k = 0; k < randomCount; k++) begin
			rs = 5'($urandom);
			rt = 5'($urandom);
			rd = 5'($urandom);
			imm = 16'($urandom);
			case ($urandom % 3)
				0: send(rType(rs, rt, rd, 5'd0, `ADDU), fRegWrite, rd, `ALU_ADDU, `BR_NONE);
				1: send(iType(`LW, rs, rt, imm), fRegWrite | fMemRead | fMemToReg, rt,
					`ALU_ADDU, `BR_NONE);
				default: send(iType(`BNE, rs, rt, imm), fNone, 5'd0, `ALU_PASS, `BR_NE);
			endcase
		end
	endtask

	task automatic bypassTest();
		decodePkg::regAddrT r;
		int k;
		for (k = 0; k < 6; k++) begin
			r = 5'(1 + ($urandom % 31));
			wbEn = 1'b1;
			wbAddr = r;
			wbData = $urandom;
			send(rType(r, r, 5'd9, 5'd0, `ADDU), fRegWrite, 5'd9, `ALU_ADDU, `BR_NONE);
		end
		// write to $0 must not reach the operands
		wbEn = 1'b1;
		wbAddr = 5'd0;
		wbData = 32'hdeadbeef;
		send(rType(5'd0, 5'd0, 5'd4, 5'd0, `OR), fRegWrite, 5'd4, `ALU_OR, `BR_NONE);
		send(rType(5'd0, 5'd0, 5'd4, 5'd0, `OR), fRegWrite, 5'd4, `ALU_OR, `BR_NONE);
	endtask

	initial begin
		void'($urandom(32'h196a));
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		wbEn = 1'b0;
		wbAddr = '0;
		wbData = '0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		loadRegs();
		rTypeTest();
		reportTest("r-type alu and shifts");
		memImmTest();
		reportTest("loads, stores, immediates");
		branchTest();
		reportTest("branches and links");
		specialTest();
		reportTest("reserved and system");
		setStall(1'b1);
		randomTest();
		reportTest("random stream with stalls");
		bypassTest();
		reportTest("write-back bypass and $0");
		if (checkCount != sentCount) begin
			$display("%0d instructions sent but %0d came out", sentCount, checkCount);
			errCount++;
		end
		$display("tests %0d, instructions %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("timeout: decode stage stopped making progress");
		$display("Test failed");
		$finish;
	end

endmodule

// File: mainDecoder.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mainDecoder (
	input  decodePkg::instrT instr,
	output logic signExt,
	output logic regWrite,
	output logic isImm,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic reserved,
	output logic isBreak,
	output logic isSyscall,
	output logic isEret,
	output logic cp0Write,
	output logic cp0ToReg,
	output logic isMfc,
	output logic mfhi,
	output logic mflo,
	output logic hiloToReg,
	output logic mulDivEn,
	output decodePkg::regDstT regDst,
	output decodePkg::aluOpT aluOp,
	output decodePkg::branchCtrlT branchCtrl
);
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] sa;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign sa = instr[10:6];
	assign funct = instr[5:0];

	assign signExt = (op[5:2] != 4'b0011);   // ANDI, ORI, XORI, LUI zero-extend
	assign mfhi = (op == `R_TYPE) && (funct == `MFHI);
	assign mflo = (op == `R_TYPE) && (funct == `MFLO);
	assign hiloToReg = mfhi || mflo;
	assign isSyscall = (op == `R_TYPE) && (funct == `SYSCALL);
	assign isBreak = (op == `R_TYPE) && (funct == `BREAK);
	assign cp0Write = (op == `COP0_INST) && (rs == `MTC0);
	assign cp0ToReg = (op == `COP0_INST) && (rs == `MFC0);
	assign isEret = (op == `COP0_INST) && (rs == `ERET_RS) && (funct == `ERET_FUNCT);

	always_comb begin
		// no-op defaults, also what a reserved encoding ends up with
		{regWrite, regDst, isImm} = 4'b0000;
		{memToReg, memRead, memWrite} = 3'b000;
		aluOp = `USELESS_OP;
		reserved = 1'b0;
		isMfc = 1'b0;
		mulDivEn = 1'b0;
		branchCtrl = `BR_NONE;
		case (op)
			`R_TYPE: begin
				aluOp = `R_TYPE_OP;
				case (funct)
					`ADD, `ADDU, `SUB, `SUBU, `SLT, `SLTU, `AND, `OR, `XOR, `NOR,
					`SLL, `SRA, `SLLV, `SRAV, `MOVN, `MOVZ, `MFHI, `MFLO, `JALR:
						regWrite = 1'b1;
					`SRL: begin
						regWrite = 1'b1;
						if (rs[0])
							aluOp = `ROTR_OP;
					end
					`SRLV: begin
						regWrite = 1'b1;
						if (sa[0])
							aluOp = `ROTRV_OP;
					end
					`MULT, `MULTU, `DIV, `DIVU:
						mulDivEn = 1'b1;
					`JR, `MTHI, `MTLO, `SYSCALL, `BREAK:
						aluOp = `R_TYPE_OP;   // no register write
					default: begin
						aluOp = `USELESS_OP;
						reserved = 1'b1;
					end
				endcase
			end
			`ADDI, `ADDIU, `SLTI, `SLTIU, `ANDI, `ORI, `XORI, `LUI: begin
				{regWrite, regDst, isImm} = 4'b1011;
				case (op)
					`ADDI: aluOp = `ADDI_OP;
					`ADDIU: aluOp = `ADDIU_OP;
					`SLTI: aluOp = `SLTI_OP;
					`SLTIU: aluOp = `SLTIU_OP;
					`ANDI: aluOp = `ANDI_OP;
					`ORI: aluOp = `ORI_OP;
					`XORI: aluOp = `XORI_OP;
					default: aluOp = `LUI_OP;
				endcase
			end
			`BEQ: branchCtrl = `BR_EQ;
			`BNE: branchCtrl = `BR_NE;
			`BLEZ: branchCtrl = `BR_LEZ;
			`BGTZ: branchCtrl = `BR_GTZ;
			`REGIMM_INST: begin
				case (rt)
					`BLTZ: branchCtrl = `BR_LTZ;
					`BGEZ: branchCtrl = `BR_GEZ;
					`BLTZAL: begin
						branchCtrl = `BR_LTZ;
						{regWrite, regDst} = 3'b110;   // link into $31
					end
					`BGEZAL: begin
						branchCtrl = `BR_GEZ;
						{regWrite, regDst} = 3'b110;
					end
					default: reserved = 1'b1;
				endcase
			end
			`LB, `LH, `LWL, `LW, `LBU, `LHU, `LWR: begin
				aluOp = `MEM_OP;
				{regWrite, regDst, isImm} = 4'b1011;
				{memToReg, memRead, memWrite} = 3'b110;
			end
			`SB, `SH, `SWL, `SW, `SWR: begin
				aluOp = `MEM_OP;
				isImm = 1'b1;
				memWrite = 1'b1;
			end
			`J: branchCtrl = `BR_NONE;
			`JAL: {regWrite, regDst} = 3'b110;
			`COP0_INST: begin
				case (rs)
					`MTC0: aluOp = `MTC0_OP;
					`MFC0: begin
						aluOp = `MFC0_OP;
						isMfc = 1'b1;
						{regWrite, regDst} = 3'b101;   // cp0 value into rt
					end
					default: reserved = !isEret;
				endcase
			end
			`SPECIAL2_INST: begin
				aluOp = `SPECIAL2_OP;
				case (funct)
					`CLO, `CLZ: regWrite = 1'b1;
					`MUL: begin
						regWrite = 1'b1;
						mulDivEn = 1'b1;
					end
					`MADD, `MADDU, `MSUB, `MSUBU: mulDivEn = 1'b1;   // hi/lo only
					default: begin
						aluOp = `USELESS_OP;
						reserved = 1'b1;
					end
				endcase
			end
			`SPECIAL3_INST: begin
				case (funct)
					`BSHFL: begin
						regWrite = 1'b1;
						case (sa)
							`SEB: aluOp = `SEB_OP;
							`SEH: aluOp = `SEH_OP;
							`WSBH: aluOp = `WSBH_OP;
							default: begin
								regWrite = 1'b0;
								reserved = 1'b1;
							end
						endcase
					end
					`EXT: begin
						aluOp = `EXT_OP;
						{regWrite, regDst} = 3'b101;
					end
					`INS: begin
						aluOp = `INS_OP;
						{regWrite, regDst} = 3'b101;
					end
					default: reserved = 1'b1;
				endcase
			end
			default: reserved = 1'b1;
		endcase
	end

	always_comb begin
		assert (!(memRead && memWrite))
			else $error("mainDecoder: load and store decoded together at %0t", $time);
	end

endmodule

// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// opcodes
`define R_TYPE          6'b000000
`define REGIMM_INST     6'b000001
`define J               6'b000010
`define JAL             6'b000011
`define BEQ             6'b000100
`define BNE             6'b000101
`define BLEZ            6'b000110
`define BGTZ            6'b000111
`define ADDI            6'b001000
`define ADDIU           6'b001001
`define SLTI            6'b001010
`define SLTIU           6'b001011
`define ANDI            6'b001100
`define ORI             6'b001101
`define XORI            6'b001110
`define LUI             6'b001111
`define COP0_INST       6'b010000
`define SPECIAL2_INST   6'b011100
`define SPECIAL3_INST   6'b011111
`define LB              6'b100000
`define LH              6'b100001
`define LWL             6'b100010
`define LW              6'b100011
`define LBU             6'b100100
`define LHU             6'b100101
`define LWR             6'b100110
`define SB              6'b101000
`define SH              6'b101001
`define SWL             6'b101010
`define SW              6'b101011
`define SWR             6'b101110

// SPECIAL funct
`define SLL             6'b000000
`define SRL             6'b000010   // ROTR when bit 21 set
`define SRA             6'b000011
`define SLLV            6'b000100
`define SRLV            6'b000110   // ROTRV when bit 6 set
`define SRAV            6'b000111
`define JR              6'b001000
`define JALR            6'b001001
`define MOVZ            6'b001010
`define MOVN            6'b001011
`define SYSCALL         6'b001100
`define BREAK           6'b001101
`define MFHI            6'b010000
`define MTHI            6'b010001
`define MFLO            6'b010010
`define MTLO            6'b010011
`define MULT            6'b011000
`define MULTU           6'b011001
`define DIV             6'b011010
`define DIVU            6'b011011
`define ADD             6'b100000
`define ADDU            6'b100001
`define SUB             6'b100010
`define SUBU            6'b100011
`define AND             6'b100100
`define OR              6'b100101
`define XOR             6'b100110
`define NOR             6'b100111
`define SLT             6'b101010
`define SLTU            6'b101011

// SPECIAL2 and SPECIAL3 funct
`define MADD            6'b000000
`define MADDU           6'b000001
`define MUL             6'b000010
`define MSUB            6'b000100
`define MSUBU           6'b000101
`define CLZ             6'b100000
`define CLO             6'b100001
`define EXT             6'b000000
`define INS             6'b000100
`define BSHFL           6'b100000

// BSHFL sa field
`define WSBH            5'b00010
`define SEB             5'b10000
`define SEH             5'b11000

// COP0 rs field
`define MFC0            5'b00000
`define MTC0            5'b00100
`define ERET_RS         5'b10000
`define ERET_FUNCT      6'b011000

// REGIMM rt field
`define BLTZ            5'b00000
`define BGEZ            5'b00001
`define BLTZAL          5'b10000
`define BGEZAL          5'b10001

// ALU op classes from the main decoder
`define R_TYPE_OP       6'd0
`define ADDI_OP         6'd1
`define ADDIU_OP        6'd2
`define SLTI_OP         6'd3
`define SLTIU_OP        6'd4
`define ANDI_OP         6'd5
`define ORI_OP          6'd6
`define XORI_OP         6'd7
`define LUI_OP          6'd8
`define MEM_OP          6'd9
`define ROTR_OP         6'd10
`define ROTRV_OP        6'd11
`define SPECIAL2_OP     6'd12
`define SEB_OP          6'd13
`define SEH_OP          6'd14
`define WSBH_OP         6'd15
`define EXT_OP          6'd16
`define INS_OP          6'd17
`define MTC0_OP         6'd18
`define MFC0_OP         6'd19
`define USELESS_OP      6'd63

// final ALU function codes
`define ALU_ADD         5'd0
`define ALU_ADDU        5'd1
`define ALU_SUB         5'd2
`define ALU_SUBU        5'd3
`define ALU_AND         5'd4
`define ALU_OR          5'd5
`define ALU_XOR         5'd6
`define ALU_NOR         5'd7
`define ALU_SLT         5'd8
`define ALU_SLTU        5'd9
`define ALU_SLL         5'd10
`define ALU_SRL         5'd11
`define ALU_SRA         5'd12
`define ALU_ROTR        5'd13
`define ALU_SLLV        5'd14
`define ALU_SRLV        5'd15
`define ALU_SRAV        5'd16
`define ALU_ROTRV       5'd17
`define ALU_LUI         5'd18
`define ALU_CLO         5'd19
`define ALU_CLZ         5'd20
`define ALU_MUL         5'd21
`define ALU_SEB         5'd22
`define ALU_SEH         5'd23
`define ALU_WSBH        5'd24
`define ALU_EXT         5'd25
`define ALU_INS         5'd26
`define ALU_MOVZ        5'd27
`define ALU_MOVN        5'd28
`define ALU_PASS        5'd31

// branch conditions
`define BR_NONE         3'd0
`define BR_EQ           3'd1
`define BR_NE           3'd2
`define BR_LEZ          3'd3
`define BR_GTZ          3'd4
`define BR_LTZ          3'd5
`define BR_GEZ          3'd6

// destination select
`define DST_RD          2'b00
`define DST_RT          2'b01
`define DST_LINK        2'b10
`define REG_LINK        5'd31

`endif

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic clk,
	input  logic rstN,
	input  decodePkg::regAddrT readAddrA,
	input  decodePkg::regAddrT readAddrB,
	output decodePkg::wordT readDataA,
	output decodePkg::wordT readDataB,
	input  logic writeEn,
	input  decodePkg::regAddrT writeAddr,
	input  decodePkg::wordT writeData
);
	decodePkg::wordT regs [32];

	always_ff @(posedge clk) begin
		if (writeEn && (writeAddr != '0))
			regs[writeAddr] <= writeData;
	end

	// $0 first, then same-cycle write-back bypass
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && (writeAddr == readAddrA)) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && (writeAddr == readAddrB)) ? writeData : regs[readAddrB];

	// a write to $0 never makes it readable as nonzero
	assert property (@(posedge clk) disable iff (!rstN)
		(writeEn && (writeAddr == '0)) ##1 ((readAddrA == '0) || (readAddrB == '0))
		|-> (((readAddrA != '0) || (readDataA == '0)) &&
			((readAddrB != '0) || (readDataB == '0))))
		else $error("regFile: register 0 read nonzero at %0t", $time);

endmodule

// File: src.f
+incdir+.
decodePkg.sv
mainDecoder.sv
aluDecoder.sv
branchJudge.sv
regFile.sv
decodeStage.sv
tbClock.sv
decodeStage_tb.sv

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs = 40
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(periodNs / 2) clk = ~clk;

endmodule
